//--- Makefile
SIM := obj_dir/Vtb_split_cache

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "^All tests passed$$" sim.log

$(SIM): vlog.f source/cache_defs.svh $(shell grep -v '^+' vlog.f)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_split_cache \
		-f vlog.f -o Vtb_split_cache

clean:
	rm -rf obj_dir sim.log

//--- sim/line_memory_model.sv
`default_nettype none
`include "cache_defs.svh"

module line_memory_model #(
	parameter logic [15:0] FILL_KEY = 16'h0000
) (
	input  wire logic              clk,
	input  wire mem_pkg::mem_req_t i_mem_req,
	output mem_pkg::line_t         o_rdata
);

	localparam int LINES = 2 ** $bits(mem_pkg::line_addr_t);

	mem_pkg::line_t      lines [LINES];
	mem_pkg::line_addr_t rd_addr = '0;
	int                  delay   = 0;       // counts down to the cycle the line is due

	initial begin
		logic [15:0] a;
		for (int l = 0; l < LINES; l++) begin
			for (int w = 0; w < `LINE_WORDS; w++) begin
				a = 16'(l * `LINE_WORDS + w);
				lines[l][w * `WORD_SIZE +: `WORD_SIZE] = (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ FILL_KEY;
			end
		end
	end

	always @(posedge clk) begin
		if (i_mem_req.wr) begin
			lines[i_mem_req.line_addr] <= i_mem_req.wline;
		end
		if (i_mem_req.rd) begin
			rd_addr <= i_mem_req.line_addr;
			delay   <= `MEM_LATENCY;
		end else if (delay != 0) begin
			delay <= delay - 1;
		end
	end

	assign o_rdata = (delay == 1) ? lines[rd_addr] : '0;   // only in the last window cycle

endmodule

`default_nettype wire

//--- sim/tb_split_cache.sv
`default_nettype none
`include "cache_defs.svh"

module tb_split_cache;

	localparam int          N_REQ    = 400;             // requests per port
	localparam int          WATCHDOG = 2 * N_REQ * 40;  // cycles for all requests
	localparam logic [15:0] FILL_KEY = 16'h5ac3;

	logic                  clk;
	logic                  reset_n;
	cache_pkg::cpu_req_t   req [2];                    // 0 instruction, 1 data
	cache_pkg::cpu_req_t   ireq;
	cache_pkg::cpu_req_t   dreq;
	cache_pkg::cpu_rsp_t   irsp;
	cache_pkg::cpu_rsp_t   drsp;
	mem_pkg::mem_req_t     mem_req;
	mem_pkg::line_t        mem_rdata;
	cache_pkg::word_t      latest [64];                // value the data side must return
	cache_pkg::word_t      mem_words [64];             // value held by memory
	cache_pkg::tag_t       i_tag [`BLOCK_NUM];
	cache_pkg::tag_t       d_tag [`BLOCK_NUM];
	mem_pkg::line_t        i_data [`BLOCK_NUM];
	logic [`BLOCK_NUM-1:0] i_valid;
	logic [`BLOCK_NUM-1:0] d_valid;
	logic [`BLOCK_NUM-1:0] d_dirty;
	logic [1:0]            busy;
	logic [1:0]            hit;
	logic [1:0]            issued;
	logic                  i_rd_need;
	logic                  d_wb_need;
	logic                  d_rd_need;
	mem_pkg::line_addr_t   miss_addr [2];
	mem_pkg::line_addr_t   victim_addr;
	mem_pkg::line_t        victim_line;
	int                    due [2];
	int                    gap [2];
	int                    sent [2];
	int                    done_cnt [2];
	int                    seed        = 32'hd052_d028;
	int                    cycle       = 0;
	int                    last_strobe = -1;
	int                    value_errs  = 0;
	int                    proto_errs  = 0;

	assign ireq = req[0];
	assign dreq = req[1];

	split_cache_top dut (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_ireq      (ireq),
		.i_dreq      (dreq),
		.o_irsp      (irsp),
		.o_drsp      (drsp),
		.o_mem_req   (mem_req),
		.i_mem_rdata (mem_rdata)
	);

	line_memory_model #(.FILL_KEY(FILL_KEY)) u_mem (
		.clk       (clk),
		.i_mem_req (mem_req),
		.o_rdata   (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic cache_pkg::word_t preload_word(input cache_pkg::addr_t a);
		return (a * 16'h9e37) ^ {a[7:0], a[15:8]} ^ FILL_KEY;
	endfunction

	function automatic mem_pkg::line_t gather_line(input bit from_latest, input int base);
		mem_pkg::line_t l;
		for (int w = 0; w < `LINE_WORDS; w++) begin
			l[w * `WORD_SIZE +: `WORD_SIZE] = from_latest ? latest[base + w] : mem_words[base + w];
		end
		return l;
	endfunction

	task automatic report_problem(input string msg);
		proto_errs++;
		$display("ERROR in cycle %0d: %s", cycle, msg);
	endtask

	task automatic check_word(input string name, input cache_pkg::word_t got,
			input cache_pkg::word_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAILED %s: got %h, expected %h in cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic check_line_addr(input string name, input mem_pkg::line_addr_t got,
			input mem_pkg::line_addr_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAILED %s: got %h, expected %h in cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic check_line(input string name, input mem_pkg::line_t got,
			input mem_pkg::line_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("FAILED %s: got %h, expected %h in cycle %0d", name, got, exp, cycle);
		end
	endtask

	task automatic drive_ports();
		int r;
		for (int p = 0; p < 2; p++) begin
			issued[p] = 1'b0;
			if (!busy[p] && (gap[p] != 0 || sent[p] == N_REQ)) begin
				req[p].req = 1'b0;
				if (gap[p] != 0) begin
					gap[p]--;
				end
			end else if (!busy[p]) begin
				r             = $random(seed);
				req[p].req    = 1'b1;
				req[p].write  = (p == 1) && r[8];
				req[p].addr   = {10'b0, r[5:0]};          // four tags per index, lots of conflicts
				req[p].wdata  = cache_pkg::word_t'(r >>> 16);
				issued[p]     = 1'b1;
				sent[p]++;
			end
		end
	endtask

	task automatic monitor_cycle();
		cache_pkg::cpu_rsp_t     rsp;
		cache_pkg::addr_fields_t f;
		int                      a;
		cycle++;
		if (sent[0] + sent[1] == 0 && (irsp.ready || drsp.ready || mem_req.rd || mem_req.wr)) begin
			report_problem("ready or memory strobe seen before the first request");
		end
		// readies first, so a refill reads memory as it was before a write-back in this cycle
		for (int p = 0; p < 2; p++) begin
			rsp = (p == 0) ? irsp : drsp;
			f   = cache_pkg::addr_fields_t'(req[p].addr);
			a   = int'(req[p].addr[5:0]);
			if (busy[p] && hit[p] && cycle == due[p] && !rsp.ready) begin
				report_problem("hit did not return ready one cycle after the request");
			end
			if (rsp.ready && !busy[p]) begin
				report_problem("ready without a pending request");
			end else if (rsp.ready) begin
				if (hit[p] && cycle != due[p]) begin
					report_problem("hit returned ready late");
				end
				if (!hit[p] && ((p == 0) ? i_rd_need : (d_wb_need || d_rd_need))) begin
					report_problem("miss returned ready before its line was fetched");
				end
				if (p == 0 && !hit[0]) begin
					i_data[f.index] = gather_line(1'b0, a & ~3);
				end
				if (p == 0) begin
					check_word("o_irsp.rdata", rsp.rdata,
						i_data[f.index][f.offset * `WORD_SIZE +: `WORD_SIZE]);
				end else if (!req[1].write) begin
					check_word("o_drsp.rdata", rsp.rdata, latest[a]);
				end
				busy[p] = 1'b0;
				gap[p]  = $random(seed) & 32'h3;
				done_cnt[p]++;
			end
		end
		if (mem_req.rd || mem_req.wr) begin
			if (last_strobe >= 0 && cycle - last_strobe < `MEM_LATENCY) begin
				report_problem("memory strobes closer together than the memory latency");
			end
			last_strobe = cycle;
			if (d_wb_need) begin                           // data side wins, victim goes first
				if (!mem_req.wr || mem_req.rd) begin
					report_problem("expected the write-back of a dirty victim");
				end
				check_line_addr("o_mem_req.line_addr", mem_req.line_addr, victim_addr);
				check_line("o_mem_req.wline", mem_req.wline, victim_line);
				for (int w = 0; w < `LINE_WORDS; w++) begin
					mem_words[int'(victim_addr) * 4 + w] = victim_line[w * `WORD_SIZE +: `WORD_SIZE];
				end
				d_wb_need = 1'b0;
			end else if (d_rd_need || i_rd_need) begin
				if (!mem_req.rd || mem_req.wr) begin
					report_problem("expected a refill read strobe");
				end
				check_line_addr("o_mem_req.line_addr", mem_req.line_addr,
					d_rd_need ? miss_addr[1] : miss_addr[0]);
				if (d_rd_need) begin
					d_rd_need = 1'b0;
				end else begin
					i_rd_need = 1'b0;
				end
			end else begin
				report_problem("memory strobe without a pending miss");
			end
		end
		for (int p = 0; p < 2; p++) begin
			if (issued[p]) begin
				f            = cache_pkg::addr_fields_t'(req[p].addr);
				a            = int'(req[p].addr[5:0]);
				busy[p]      = 1'b1;
				due[p]       = cycle + 1;
				miss_addr[p] = {f.tag, f.index};
				if (p == 0) begin
					hit[0]           = i_valid[f.index] && (i_tag[f.index] == f.tag);
					i_rd_need        = !hit[0];
					i_valid[f.index] = 1'b1;
					i_tag[f.index]   = f.tag;
				end else begin
					hit[1] = d_valid[f.index] && (d_tag[f.index] == f.tag);
					if (!hit[1] && d_valid[f.index] && d_dirty[f.index]) begin
						victim_addr = {d_tag[f.index], f.index};
						victim_line = gather_line(1'b1, int'(victim_addr) * 4);
						d_wb_need   = 1'b1;
					end
					d_rd_need        = !hit[1];
					d_dirty[f.index] = (hit[1] && d_dirty[f.index]) || req[1].write;
					d_valid[f.index] = 1'b1;
					d_tag[f.index]   = f.tag;
					if (req[1].write) begin
						latest[a] = req[1].wdata;
					end
				end
			end
		end
	endtask

	initial begin
		req[0]    = '0;
		req[1]    = '0;
		reset_n   = 1'b0;
		busy      = '0;
		hit       = '0;
		issued    = '0;
		i_valid   = '0;
		d_valid   = '0;
		d_dirty   = '0;
		i_rd_need = 1'b0;
		d_wb_need = 1'b0;
		d_rd_need = 1'b0;
		for (int p = 0; p < 2; p++) begin
			due[p]      = 0;
			gap[p]      = 3 + p;                           // quiet cycles after reset
			sent[p]     = 0;
			done_cnt[p] = 0;
		end
		for (int a = 0; a < 64; a++) begin
			mem_words[a] = preload_word(16'(a));
			latest[a]    = mem_words[a];
		end
		repeat (5) @(posedge clk);
		#1 reset_n = 1'b1;
		while (done_cnt[0] < N_REQ || done_cnt[1] < N_REQ) begin
			@(negedge clk);
			monitor_cycle();
			@(posedge clk);
			#1;
			drive_ports();
		end
		$display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs);
		if (value_errs == 0 && proto_errs == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge clk);
		$display("ERROR: run did not finish within %0d cycles, a port stopped answering", WATCHDOG);
		$display("errors: %0d wrong values, %0d protocol", value_errs, proto_errs + 1);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- source/cache_defs.svh
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// cpu word and address width
`define WORD_SIZE 16

// words per cache line
`define LINE_WORDS 4

// line width in bits
`define LINE_SIZE (`WORD_SIZE * `LINE_WORDS)

// lines per cache, direct mapped
`define BLOCK_NUM 4

// address bits above index and offset
`define TAG_SIZE 12

// cycles from strobe to end of a line transfer
`define MEM_LATENCY 4

`endif

//--- source/cache_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package cache_pkg;

	typedef logic [`WORD_SIZE-1:0]           word_t;
	typedef logic [`WORD_SIZE-1:0]           addr_t;
	typedef logic [`TAG_SIZE-1:0]            tag_t;
	typedef logic [$clog2(`BLOCK_NUM)-1:0]   index_t;
	typedef logic [$clog2(`LINE_WORDS)-1:0]  offset_t;

	// msb to lsb, same split as the cpu address
	typedef struct packed {
		tag_t    tag;
		index_t  index;
		offset_t offset;
	} addr_fields_t;

	// held by the cpu until ready
	typedef struct packed {
		logic  req;    // request level
		logic  write;  // 1 store, 0 load
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	typedef struct packed {
		logic  ready;  // one cycle pulse
		word_t rdata;  // valid with ready on loads
	} cpu_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		WRITE_BACK,
		REFILL,
		READY
	} cache_state_t;

endpackage

`default_nettype wire

//--- source/dcache.sv
`default_nettype none
`include "cache_defs.svh"

module dcache (
	input  wire logic                clk,
	input  wire logic                reset_n,
	input  wire cache_pkg::cpu_req_t i_req,
	output cache_pkg::cpu_rsp_t      o_rsp,
	output mem_pkg::mem_req_t        o_mem_req,
	input  wire logic                i_grant,
	input  wire mem_pkg::mem_rsp_t   i_mem_rsp
);

	cache_pkg::addr_fields_t fields;
	cache_pkg::cache_state_t state;
	logic                    mem_wait;                // granted transfer still running
	cache_pkg::tag_t         tag_bank [`BLOCK_NUM];
	logic [`BLOCK_NUM-1:0]   valid;
	logic [`BLOCK_NUM-1:0]   dirty;
	mem_pkg::line_t          data_bank [`BLOCK_NUM];
	mem_pkg::line_t          fill_line;               // refill line with store merged
	logic                    hit;
	logic                    victim_dirty;

	assign fields       = cache_pkg::addr_fields_t'(i_req.addr);
	assign hit          = valid[fields.index] && (tag_bank[fields.index] == fields.tag);
	assign victim_dirty = valid[fields.index] && dirty[fields.index];

	always_comb begin
		fill_line = i_mem_rsp.rline;
		if (i_req.write) begin
			fill_line[fields.offset * `WORD_SIZE +: `WORD_SIZE] = i_req.wdata;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state    <= cache_pkg::IDLE;
			mem_wait <= 1'b0;
			valid    <= '0;
			dirty    <= '0;
			for (int b = 0; b < `BLOCK_NUM; b++) begin
				tag_bank[b]  <= '0;
				data_bank[b] <= '0;
			end
		end else begin
			case (state)
				cache_pkg::IDLE: begin
					if (i_req.req) begin
						if (hit) begin
							if (i_req.write) begin
								data_bank[fields.index][fields.offset * `WORD_SIZE +: `WORD_SIZE]
									<= i_req.wdata;                 // write hit
								dirty[fields.index] <= 1'b1;
							end
							state <= cache_pkg::READY;
						end else if (victim_dirty) begin
							state <= cache_pkg::WRITE_BACK;
						end else begin
							state <= cache_pkg::REFILL;
						end
					end
				end
				cache_pkg::WRITE_BACK: begin
					if (i_grant) begin
						mem_wait <= 1'b1;
					end
					if (i_mem_rsp.valid) begin
						mem_wait <= 1'b0;                     // victim now in memory
						state    <= cache_pkg::REFILL;
					end
				end
				cache_pkg::REFILL: begin
					if (i_grant) begin
						mem_wait <= 1'b1;
					end
					if (i_mem_rsp.valid) begin
						data_bank[fields.index] <= fill_line;
						tag_bank[fields.index]  <= fields.tag;
						valid[fields.index]     <= 1'b1;
						dirty[fields.index]     <= i_req.write;   // clean on a load miss
						mem_wait                <= 1'b0;
						state                   <= cache_pkg::READY;
					end
				end
				cache_pkg::READY: begin
					state <= cache_pkg::IDLE;
				end
			endcase
		end
	end

	assign o_rsp.ready = (state == cache_pkg::READY);
	assign o_rsp.rdata = data_bank[fields.index][fields.offset * `WORD_SIZE +: `WORD_SIZE];

	assign o_mem_req.rd = (state == cache_pkg::REFILL) && !mem_wait;
	assign o_mem_req.wr = (state == cache_pkg::WRITE_BACK) && !mem_wait;

	// line address of the victim or of the request
	assign o_mem_req.line_addr = (state == cache_pkg::WRITE_BACK) ?
		{tag_bank[fields.index], fields.index} : {fields.tag, fields.index};
	assign o_mem_req.wline     = data_bank[fields.index];

	// writes leave only from a dirty victim during write-back
	a_wr_in_wb: assert property (@(posedge clk) disable iff (!reset_n)
		o_mem_req.wr |-> (state == cache_pkg::WRITE_BACK) && dirty[fields.index]);

endmodule

`default_nettype wire

//--- source/icache.sv
`default_nettype none
`include "cache_defs.svh"

module icache (
	input  wire logic                clk,
	input  wire logic                reset_n,
	input  wire cache_pkg::cpu_req_t i_req,
	output cache_pkg::cpu_rsp_t      o_rsp,
	output mem_pkg::mem_req_t        o_mem_req,
	input  wire logic                i_grant,
	input  wire mem_pkg::mem_rsp_t   i_mem_rsp
);

	cache_pkg::addr_fields_t fields;
	cache_pkg::cache_state_t state;
	logic                    mem_wait;                // read granted, line pending
	cache_pkg::tag_t         tag_bank [`BLOCK_NUM];
	logic [`BLOCK_NUM-1:0]   valid;
	mem_pkg::line_t          data_bank [`BLOCK_NUM];
	logic                    hit;

	assign fields = cache_pkg::addr_fields_t'(i_req.addr);
	assign hit    = valid[fields.index] && (tag_bank[fields.index] == fields.tag);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			state    <= cache_pkg::IDLE;
			mem_wait <= 1'b0;
			valid    <= '0;
			for (int b = 0; b < `BLOCK_NUM; b++) begin
				tag_bank[b]  <= '0;
				data_bank[b] <= '0;
			end
		end else begin
			case (state)
				cache_pkg::IDLE: begin
					if (i_req.req) begin
						state <= hit ? cache_pkg::READY : cache_pkg::REFILL;
					end
				end
				cache_pkg::REFILL: begin
					if (i_grant) begin
						mem_wait <= 1'b1;                     // drop strobe
					end
					if (i_mem_rsp.valid) begin
						data_bank[fields.index] <= i_mem_rsp.rline;
						tag_bank[fields.index]  <= fields.tag;
						valid[fields.index]     <= 1'b1;
						mem_wait                <= 1'b0;
						state                   <= cache_pkg::READY;
					end
				end
				default: begin
					state <= cache_pkg::IDLE;                 // ready pulse done
				end
			endcase
		end
	end

	assign o_rsp.ready = (state == cache_pkg::READY);
	assign o_rsp.rdata = data_bank[fields.index][fields.offset * `WORD_SIZE +: `WORD_SIZE];

	assign o_mem_req.rd        = (state == cache_pkg::REFILL) && !mem_wait;
	assign o_mem_req.wr        = 1'b0;                    // read only
	assign o_mem_req.line_addr = {fields.tag, fields.index};
	assign o_mem_req.wline     = '0;

	// instruction side never writes memory
	a_no_write: assert property (@(posedge clk) disable iff (!reset_n)
		!o_mem_req.wr);

	// a line only comes back for a read this cache was granted
	a_rsp_owned: assert property (@(posedge clk) disable iff (!reset_n)
		i_mem_rsp.valid |-> (state == cache_pkg::REFILL) && mem_wait);

endmodule

`default_nettype wire

//--- source/mem_arbiter.sv
`default_nettype none
`include "cache_defs.svh"

module mem_arbiter (
	input  wire logic              clk,
	input  wire logic              reset_n,
	input  wire mem_pkg::mem_req_t i_ireq,
	input  wire mem_pkg::mem_req_t i_dreq,
	output logic                   o_igrant,
	output logic                   o_dgrant,
	output mem_pkg::mem_rsp_t      o_irsp,
	output mem_pkg::mem_rsp_t      o_drsp,
	output mem_pkg::mem_req_t      o_mem_req,
	input  wire mem_pkg::line_t    i_mem_rdata
);

	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	logic             busy;       // transfer window open
	logic             owner_d;    // 1 data cache, 0 instruction cache
	logic             xfer_rd;    // current transfer is a read
	logic [CNT_W-1:0] cnt;        // cycles left in the window
	logic             i_strobe;
	logic             d_strobe;
	logic             done;
	mem_pkg::line_t   rsp_line;

	assign i_strobe = i_ireq.rd || i_ireq.wr;
	assign d_strobe = i_dreq.rd || i_dreq.wr;

	// data side wins a tie
	assign o_dgrant = !busy && d_strobe;
	assign o_igrant = !busy && i_strobe && !d_strobe;

	always_comb begin
		if (o_dgrant) begin
			o_mem_req = i_dreq;
		end else if (o_igrant) begin
			o_mem_req = i_ireq;
		end else begin
			o_mem_req = '0;
		end
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			busy    <= 1'b0;
			owner_d <= 1'b0;
			xfer_rd <= 1'b0;
			cnt     <= '0;
		end else if (o_dgrant || o_igrant) begin
			busy    <= 1'b1;
			owner_d <= o_dgrant;
			xfer_rd <= o_mem_req.rd;
			cnt     <= CNT_W'(`MEM_LATENCY - 1);
		end else if (done) begin
			busy <= 1'b0;
		end else if (busy) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign done     = busy && (cnt == '0);      // memory data valid this cycle
	assign rsp_line = xfer_rd ? i_mem_rdata : '0;

	assign o_drsp.valid = done && owner_d;
	assign o_drsp.rline = rsp_line;
	assign o_irsp.valid = done && !owner_d;
	assign o_irsp.rline = rsp_line;

	a_one_grant: assert property (@(posedge clk) disable iff (!reset_n)
		!(o_igrant && o_dgrant));

	// strobes are spaced by at least the memory latency
	a_strobe_gap: assert property (@(posedge clk) disable iff (!reset_n)
		(o_mem_req.rd || o_mem_req.wr) |=>
			!(o_mem_req.rd || o_mem_req.wr) [*`MEM_LATENCY]);

endmodule

`default_nettype wire

//--- source/mem_pkg.sv
`default_nettype none
`include "cache_defs.svh"

package mem_pkg;

	typedef logic [`LINE_SIZE-1:0] line_t;

	// tag and index, no word offset
	typedef logic [`TAG_SIZE+$clog2(`BLOCK_NUM)-1:0] line_addr_t;

	// strobes stay up until the arbiter grants
	typedef struct packed {
		logic       rd;
		logic       wr;
		line_addr_t line_addr;
		line_t      wline;      // victim line on writes
	} mem_req_t;

	typedef struct packed {
		logic  valid;  // end of transfer pulse
		line_t rline;  // refill line, zero after a write
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- source/split_cache_top.sv
`default_nettype none

module split_cache_top (
	input  wire logic                clk,
	input  wire logic                reset_n,
	input  wire cache_pkg::cpu_req_t i_ireq,
	input  wire cache_pkg::cpu_req_t i_dreq,
	output cache_pkg::cpu_rsp_t      o_irsp,
	output cache_pkg::cpu_rsp_t      o_drsp,
	output mem_pkg::mem_req_t        o_mem_req,
	input  wire mem_pkg::line_t      i_mem_rdata
);

	mem_pkg::mem_req_t icache_mem_req;
	mem_pkg::mem_req_t dcache_mem_req;
	mem_pkg::mem_rsp_t icache_mem_rsp;
	mem_pkg::mem_rsp_t dcache_mem_rsp;
	logic              igrant;
	logic              dgrant;

	icache u_icache (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_req     (i_ireq),
		.o_rsp     (o_irsp),
		.o_mem_req (icache_mem_req),
		.i_grant   (igrant),
		.i_mem_rsp (icache_mem_rsp)
	);

	dcache u_dcache (
		.clk       (clk),
		.reset_n   (reset_n),
		.i_req     (i_dreq),
		.o_rsp     (o_drsp),
		.o_mem_req (dcache_mem_req),
		.i_grant   (dgrant),
		.i_mem_rsp (dcache_mem_rsp)
	);

	// single line port shared by both caches
	mem_arbiter u_mem_arbiter (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_ireq      (icache_mem_req),
		.i_dreq      (dcache_mem_req),
		.o_igrant    (igrant),
		.o_dgrant    (dgrant),
		.o_irsp      (icache_mem_rsp),
		.o_drsp      (dcache_mem_rsp),
		.o_mem_req   (o_mem_req),
		.i_mem_rdata (i_mem_rdata)
	);

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/cache_pkg.sv
source/mem_pkg.sv
source/icache.sv
source/dcache.sv
source/mem_arbiter.sv
source/split_cache_top.sv
sim/line_memory_model.sv
sim/tb_split_cache.sv
